// ==== source/mem_subsys_pkg.sv ====
/* Memory subsystem shared constants */

`default_nettype none

package mem_subsys_pkg;

  // ====================
  // Widths and depths
  // ====================

  // Data and address word width
  localparam int WORD_W = 32;

  // Words per RAM, 16 KB each
  localparam int RAM_DEPTH = 4096;

  // Word index width, taken from address bits 13:2
  localparam int RAM_AW = 12;

  // APB offset width, low 13 address bits
  localparam int APB_AW = 13;

  // ====================
  // Memory map
  // ====================

  // Debug area, routed to APB while debug mode is on
  localparam logic [WORD_W-1:0] DEBUG_AREA_START = 32'h4000_0000;
  localparam logic [WORD_W-1:0] DEBUG_AREA_END   = 32'h4000_1FFF;

  // Host communication word
  localparam logic [WORD_W-1:0] TOHOST_ADDR = 32'h8000_1000;

  // ====================
  // Fill values
  // ====================

  // addi x0, x0, 0
  localparam logic [WORD_W-1:0] NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== source/init_loader.sv ====
/* Init port loader */

`timescale 1ns/1ps
`default_nettype none

module init_loader
  import mem_subsys_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,
  input  wire logic [WORD_W-1:0] i_init_addr,
  input  wire logic [WORD_W-1:0] i_init_data,
  input  wire logic              i_init_wen,
  output logic                   o_load_en,
  output logic [RAM_AW-1:0]      o_load_idx,
  output logic [WORD_W-1:0]      o_load_data,
  output logic                   o_unavailable
);

  logic wen_prev;
  logic busy;
  logic in_window;

  // Busy flag follows init wen edges
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wen_prev <= 1'b0;
      busy     <= 1'b0;
    end else begin
      wen_prev <= i_init_wen;
      // Rising edge opens the load phase
      if (i_init_wen && !wen_prev) begin
        busy <= 1'b1;
      end else if (!i_init_wen && wen_prev) begin
        busy <= 1'b0;
      end
    end
  end

  // Low 16 KB window only
  assign in_window = (i_init_addr[15:14] == 2'b00);

  // Load strobe goes to both RAMs
  assign o_load_en     = i_init_wen && in_window;
  assign o_load_idx    = i_init_addr[RAM_AW+1:2];
  assign o_load_data   = i_init_data;
  assign o_unavailable = busy;

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
/* Instruction RAM and fetch */

`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import mem_subsys_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,
  input  wire logic              i_load_en,
  input  wire logic [RAM_AW-1:0] i_load_idx,
  input  wire logic [WORD_W-1:0] i_load_data,
  input  wire logic [WORD_W-1:0] i_imem_addr,
  input  wire logic              i_imem_rready,
  output logic [WORD_W-1:0]      o_imem_rdata,
  output logic                   o_imem_rvalid
);

  // ====================
  // Storage
  // ====================

  logic [WORD_W-1:0] mem [RAM_DEPTH];
  logic [WORD_W-1:0] rdata_q;
  logic              rvalid_q;
  logic [RAM_AW-1:0] fetch_idx;

  // Start from an all-NOP image
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = NOP_WORD;
    end
  end

  // Init load port
  always_ff @(posedge clk) begin
    if (i_load_en) begin
      mem[i_load_idx] <= i_load_data;
    end
  end

  // ====================
  // Fetch path
  // ====================

  // Byte address to word index
  assign fetch_idx = i_imem_addr[RAM_AW+1:2];

  // Registered read, only on request
  always_ff @(posedge clk) begin
    if (i_imem_rready) begin
      rdata_q <= mem[fetch_idx];
    end
  end

  // Valid one cycle after request
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= i_imem_rready;
    end
  end

  assign o_imem_rdata  = rdata_q;
  assign o_imem_rvalid = rvalid_q;

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
/* Data RAM */

`timescale 1ns/1ps
`default_nettype none

module data_ram
  import mem_subsys_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              i_we,
  input  wire logic              i_re,
  input  wire logic [RAM_AW-1:0] i_idx,
  input  wire logic [WORD_W-1:0] i_wdata,
  input  wire logic              i_load_en,
  input  wire logic [RAM_AW-1:0] i_load_idx,
  input  wire logic [WORD_W-1:0] i_load_data,
  output logic [WORD_W-1:0]      o_rdata
);

  logic [WORD_W-1:0] mem [RAM_DEPTH];
  logic [WORD_W-1:0] rdata_q;

  // Power-up contents
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = NOP_WORD;
    end
  end

  // ====================
  // Write ports
  // ====================

  // Init and access writes share one process
  // Access write wins on a same-word collision
  always_ff @(posedge clk) begin
    if (i_load_en) begin
      mem[i_load_idx] <= i_load_data;
    end
    if (i_we) begin
      mem[i_idx] <= i_wdata;
    end
  end

  // ====================
  // Read port
  // ====================

  // Data appears the cycle after i_re
  always_ff @(posedge clk) begin
    if (i_re) begin
      rdata_q <= mem[i_idx];
    end
  end

  assign o_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/data_router.sv ====
/* Data access router */

`timescale 1ns/1ps
`default_nettype none

module data_router
  import mem_subsys_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,
  input  wire logic              i_debug_mode,
  input  wire logic [WORD_W-1:0] i_dmem_addr,
  input  wire logic [WORD_W-1:0] i_dmem_wdata,
  input  wire logic              i_dmem_wvalid,
  input  wire logic              i_dmem_rready,
  input  wire logic [WORD_W-1:0] i_ram_rdata,
  input  wire logic              i_dbg_rd_done,
  input  wire logic              i_dbg_wr_done,
  input  wire logic [WORD_W-1:0] i_dbg_rdata,
  output logic                   o_ram_we,
  output logic                   o_ram_re,
  output logic [RAM_AW-1:0]      o_ram_idx,
  output logic [WORD_W-1:0]      o_ram_wdata,
  output logic                   o_dbg_req,
  output logic                   o_dbg_write,
  output logic [APB_AW-1:0]      o_dbg_addr,
  output logic [WORD_W-1:0]      o_dbg_wdata,
  output logic [WORD_W-1:0]      o_dmem_rdata,
  output logic                   o_dmem_rvalid,
  output logic                   o_dmem_wready,
  output logic [WORD_W-1:0]      o_tohost
);

  logic in_dbg;
  logic dbg_wr;
  logic dbg_rd;
  logic rvalid_q;
  logic [WORD_W-1:0] tohost_q;

  // ====================
  // Address decode
  // ====================

  // Debug area only counts while debug mode is on
  assign in_dbg = i_debug_mode &&
                  (i_dmem_addr >= DEBUG_AREA_START) &&
                  (i_dmem_addr <= DEBUG_AREA_END);
  assign dbg_wr = in_dbg && i_dmem_wvalid;
  assign dbg_rd = in_dbg && i_dmem_rready;

  // RAM side
  assign o_ram_we    = i_dmem_wvalid && !in_dbg;
  assign o_ram_re    = i_dmem_rready && !in_dbg;
  assign o_ram_idx   = i_dmem_addr[RAM_AW+1:2];
  assign o_ram_wdata = i_dmem_wdata;

  // Bridge side, held by the requester until done
  assign o_dbg_req   = dbg_wr || dbg_rd;
  assign o_dbg_write = dbg_wr;
  assign o_dbg_addr  = i_dmem_addr[APB_AW-1:0];
  assign o_dbg_wdata = i_dmem_wdata;

  // ====================
  // Responses
  // ====================

  // Fixed one-cycle RAM read latency
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= o_ram_re;
    end
  end

  // Bridge completion is combinational
  assign o_dmem_rvalid = rvalid_q || i_dbg_rd_done;
  assign o_dmem_rdata  = i_dbg_rd_done ? i_dbg_rdata : i_ram_rdata;
  // Stall debug writes until the slave answers
  assign o_dmem_wready = !dbg_wr || i_dbg_wr_done;

  // tohost capture, the RAM write still happens
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      tohost_q <= '0;
    end else if (i_dmem_wvalid && (i_dmem_addr == TOHOST_ADDR)) begin
      tohost_q <= i_dmem_wdata;
    end
  end

  assign o_tohost = tohost_q;

endmodule

`default_nettype wire

// ==== source/dbg_apb_master.sv ====
/* Debug area APB master */

`timescale 1ns/1ps
`default_nettype none

module dbg_apb_master
  import mem_subsys_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,
  input  wire logic              i_req,
  input  wire logic              i_write,
  input  wire logic [APB_AW-1:0] i_addr,
  input  wire logic [WORD_W-1:0] i_wdata,
  input  wire logic              i_pready,
  input  wire logic [WORD_W-1:0] i_prdata,
  output logic [APB_AW-1:0]      o_paddr,
  output logic                   o_psel,
  output logic                   o_penable,
  output logic                   o_pwrite,
  output logic [WORD_W-1:0]      o_pwdata,
  output logic                   o_rd_done,
  output logic                   o_wr_done,
  output logic [WORD_W-1:0]      o_rdata
);

  // FSM state lives in psel and penable
  // IDLE   = psel low
  // SETUP  = psel high, penable low
  // ACCESS = psel and penable high
  logic psel_q;
  logic penable_q;
  logic access;
  logic done;

  // Latched transaction
  logic [APB_AW-1:0] addr_q;
  logic [WORD_W-1:0] wdata_q;
  logic              write_q;
  logic [WORD_W-1:0] resp_q;

  assign access = psel_q && penable_q;
  assign done   = access && i_pready;

  // ====================
  // State machine
  // ====================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
    end else if (!psel_q) begin
      // IDLE, start on request
      psel_q <= i_req;
    end else if (!penable_q) begin
      // SETUP lasts exactly one cycle
      penable_q <= 1'b1;
    end else if (i_pready) begin
      // ACCESS ends on pready
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
    end
  end

  // Capture request fields on entry to SETUP
  always_ff @(posedge clk) begin
    if (!psel_q && i_req) begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
      write_q <= i_write;
    end
  end

  // Keep last read response
  always_ff @(posedge clk) begin
    if (done && !write_q) begin
      resp_q <= i_prdata;
    end
  end

  // ====================
  // Outputs
  // ====================

  assign o_paddr   = addr_q;
  assign o_psel    = psel_q;
  assign o_penable = penable_q;
  assign o_pwrite  = write_q;
  assign o_pwdata  = wdata_q;

  // Completion split by direction
  assign o_rd_done = done && !write_q;
  assign o_wr_done = done && write_q;

  // Live data during ACCESS, held copy otherwise
  assign o_rdata = access ? i_prdata : resp_q;

endmodule

`default_nettype wire

// ==== source/mem_subsys_top.sv ====
/* Memory subsystem top */

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
  import mem_subsys_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_n,
  // Init port
  input  wire logic [WORD_W-1:0] i_init_addr,
  input  wire logic [WORD_W-1:0] i_init_data,
  input  wire logic              i_init_wen,
  output logic                   o_unavailable,
  input  wire logic              i_debug_mode,
  // Instruction side
  input  wire logic [WORD_W-1:0] i_imem_addr,
  input  wire logic              i_imem_rready,
  output logic [WORD_W-1:0]      o_imem_rdata,
  output logic                   o_imem_rvalid,
  // Data side
  input  wire logic [WORD_W-1:0] i_dmem_addr,
  input  wire logic [WORD_W-1:0] i_dmem_wdata,
  input  wire logic              i_dmem_wvalid,
  input  wire logic              i_dmem_rready,
  output logic [WORD_W-1:0]      o_dmem_rdata,
  output logic                   o_dmem_rvalid,
  output logic                   o_dmem_wready,
  output logic [WORD_W-1:0]      o_tohost,
  // External APB
  output logic [APB_AW-1:0]      o_apb_paddr,
  output logic                   o_apb_psel,
  output logic                   o_apb_penable,
  output logic                   o_apb_pwrite,
  output logic [WORD_W-1:0]      o_apb_pwdata,
  input  wire logic              i_apb_pready,
  input  wire logic [WORD_W-1:0] i_apb_prdata
);

  // Init load bus
  logic              load_en;
  logic [RAM_AW-1:0] load_idx;
  logic [WORD_W-1:0] load_data;

  // Data RAM controls
  logic              ram_we;
  logic              ram_re;
  logic [RAM_AW-1:0] ram_idx;
  logic [WORD_W-1:0] ram_wdata;
  logic [WORD_W-1:0] ram_rdata;

  // Bridge request and response
  logic              dbg_req;
  logic              dbg_write;
  logic [APB_AW-1:0] dbg_addr;
  logic [WORD_W-1:0] dbg_wdata;
  logic              dbg_rd_done;
  logic              dbg_wr_done;
  logic [WORD_W-1:0] dbg_rdata;

  init_loader u_init_loader (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_init_addr  (i_init_addr),
    .i_init_data  (i_init_data),
    .i_init_wen   (i_init_wen),
    .o_load_en    (load_en),
    .o_load_idx   (load_idx),
    .o_load_data  (load_data),
    .o_unavailable(o_unavailable)
  );

  fetch_unit u_fetch_unit (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_load_en    (load_en),
    .i_load_idx   (load_idx),
    .i_load_data  (load_data),
    .i_imem_addr  (i_imem_addr),
    .i_imem_rready(i_imem_rready),
    .o_imem_rdata (o_imem_rdata),
    .o_imem_rvalid(o_imem_rvalid)
  );

  data_ram u_data_ram (
    .clk        (clk),
    .i_we       (ram_we),
    .i_re       (ram_re),
    .i_idx      (ram_idx),
    .i_wdata    (ram_wdata),
    .i_load_en  (load_en),
    .i_load_idx (load_idx),
    .i_load_data(load_data),
    .o_rdata    (ram_rdata)
  );

  data_router u_data_router (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_debug_mode (i_debug_mode),
    .i_dmem_addr  (i_dmem_addr),
    .i_dmem_wdata (i_dmem_wdata),
    .i_dmem_wvalid(i_dmem_wvalid),
    .i_dmem_rready(i_dmem_rready),
    .i_ram_rdata  (ram_rdata),
    .i_dbg_rd_done(dbg_rd_done),
    .i_dbg_wr_done(dbg_wr_done),
    .i_dbg_rdata  (dbg_rdata),
    .o_ram_we     (ram_we),
    .o_ram_re     (ram_re),
    .o_ram_idx    (ram_idx),
    .o_ram_wdata  (ram_wdata),
    .o_dbg_req    (dbg_req),
    .o_dbg_write  (dbg_write),
    .o_dbg_addr   (dbg_addr),
    .o_dbg_wdata  (dbg_wdata),
    .o_dmem_rdata (o_dmem_rdata),
    .o_dmem_rvalid(o_dmem_rvalid),
    .o_dmem_wready(o_dmem_wready),
    .o_tohost     (o_tohost)
  );

  dbg_apb_master u_dbg_apb_master (
    .clk      (clk),
    .reset_n  (reset_n),
    .i_req    (dbg_req),
    .i_write  (dbg_write),
    .i_addr   (dbg_addr),
    .i_wdata  (dbg_wdata),
    .i_pready (i_apb_pready),
    .i_prdata (i_apb_prdata),
    .o_paddr  (o_apb_paddr),
    .o_psel   (o_apb_psel),
    .o_penable(o_apb_penable),
    .o_pwrite (o_apb_pwrite),
    .o_pwdata (o_apb_pwdata),
    .o_rd_done(dbg_rd_done),
    .o_wr_done(dbg_wr_done),
    .o_rdata  (dbg_rdata)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic o_clk,
  output logic o_reset_n
);

  // 100 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #50 o_clk = ~o_clk;
    end
  end

  // Reset held low over the first two rising edges
  initial begin
    o_reset_n = 1'b0;
    repeat (2) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/mem_subsys_sva.sv ====
/* Bus timing assertions */

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_sva
  import mem_subsys_pkg::*;
(
  input wire logic              clk,
  input wire logic              reset_n,
  input wire logic              i_init_wen,
  input wire logic              i_unavailable,
  input wire logic              i_debug_mode,
  input wire logic              i_imem_rready,
  input wire logic              i_imem_rvalid,
  input wire logic [WORD_W-1:0] i_dmem_addr,
  input wire logic              i_dmem_rready,
  input wire logic              i_dmem_rvalid,
  input wire logic              i_psel,
  input wire logic              i_penable,
  input wire logic              i_pready
);

  // Failure tally, read by the testbench summary
  int unsigned fail_count = 0;
  logic        in_area;
  logic        normal_rd;

  // RAM reads only, debug area excluded while debug mode is on
  assign in_area   = (i_dmem_addr >= DEBUG_AREA_START) && (i_dmem_addr <= DEBUG_AREA_END);
  assign normal_rd = i_dmem_rready && !(i_debug_mode && in_area);

  // ====================
  // Fixed latencies
  // ====================

  a_fetch_valid: assert property (@(posedge clk) disable iff (!reset_n)
    i_imem_rready |=> i_imem_rvalid)
    else begin
      fail_count = fail_count + 1;
      $error("fetch valid missing one cycle after the request");
    end

  a_read_valid: assert property (@(posedge clk) disable iff (!reset_n)
    normal_rd |=> i_dmem_rvalid)
    else begin
      fail_count = fail_count + 1;
      $error("data read valid missing one cycle after a RAM read");
    end

  // Busy level trails init wen by one edge
  a_unavailable: assert property (@(posedge clk) disable iff (!reset_n)
    i_unavailable == $past(i_init_wen))
    else begin
      fail_count = fail_count + 1;
      $error("unavailable does not follow init wen");
    end

  // ====================
  // APB protocol
  // ====================

  // ACCESS entered only from a SETUP cycle
  a_setup_first: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(i_penable) |-> ($past(i_psel) && !$past(i_penable)))
    else begin
      fail_count = fail_count + 1;
      $error("penable rose without a preceding setup cycle");
    end

  a_psel_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (i_psel && !(i_penable && i_pready)) |=> i_psel)
    else begin
      fail_count = fail_count + 1;
      $error("psel dropped before pready");
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
/* Memory subsystem testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_top
  import mem_subsys_pkg::*;
();

  // ====================
  // Run limits
  // ====================

  localparam int N_INIT = 8;
  localparam int N_DATA = 8;
  localparam int N_DBG  = 4;
  // Worst-case cycles per test plus reset
  localparam int TEST_CYCLES = 4 + (4 * N_INIT + 16) + (6 * N_DATA + 4) + 8
                             + (6 * N_DBG + 2) + (6 * (N_DBG + 1) + 2) + 10;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic              clk;
  logic              reset_n;
  logic [WORD_W-1:0] i_init_addr;
  logic [WORD_W-1:0] i_init_data;
  logic              i_init_wen;
  logic              i_debug_mode;
  logic [WORD_W-1:0] i_imem_addr;
  logic              i_imem_rready;
  logic [WORD_W-1:0] i_dmem_addr;
  logic [WORD_W-1:0] i_dmem_wdata;
  logic              i_dmem_wvalid;
  logic              i_dmem_rready;
  // Driven only by the slave model
  logic              i_apb_pready = 1'b0;
  logic [WORD_W-1:0] i_apb_prdata = '0;
  logic              o_unavailable;
  logic [WORD_W-1:0] o_imem_rdata;
  logic              o_imem_rvalid;
  logic [WORD_W-1:0] o_dmem_rdata;
  logic              o_dmem_rvalid;
  logic              o_dmem_wready;
  logic [WORD_W-1:0] o_tohost;
  logic [APB_AW-1:0] o_apb_paddr;
  logic              o_apb_psel;
  logic              o_apb_penable;
  logic              o_apb_pwrite;
  logic [WORD_W-1:0] o_apb_pwdata;

  logic [31:0] rng;
  logic [31:0] wait_rng = 32'hb50eaeb8;
  logic [31:0] slave_mem [2048];
  int errors;
  int checks;
  int test_errors;
  int tests_run;
  int cycle_count = 0;

  tb_clock u_clock (
    .o_clk    (clk),
    .o_reset_n(reset_n)
  );

  mem_subsys_top dut0 (
    .clk(clk), .reset_n(reset_n),
    .i_init_addr(i_init_addr), .i_init_data(i_init_data), .i_init_wen(i_init_wen),
    .o_unavailable(o_unavailable), .i_debug_mode(i_debug_mode),
    .i_imem_addr(i_imem_addr), .i_imem_rready(i_imem_rready),
    .o_imem_rdata(o_imem_rdata), .o_imem_rvalid(o_imem_rvalid),
    .i_dmem_addr(i_dmem_addr), .i_dmem_wdata(i_dmem_wdata),
    .i_dmem_wvalid(i_dmem_wvalid), .i_dmem_rready(i_dmem_rready),
    .o_dmem_rdata(o_dmem_rdata), .o_dmem_rvalid(o_dmem_rvalid),
    .o_dmem_wready(o_dmem_wready), .o_tohost(o_tohost),
    .o_apb_paddr(o_apb_paddr), .o_apb_psel(o_apb_psel), .o_apb_penable(o_apb_penable),
    .o_apb_pwrite(o_apb_pwrite), .o_apb_pwdata(o_apb_pwdata),
    .i_apb_pready(i_apb_pready), .i_apb_prdata(i_apb_prdata)
  );

  bind mem_subsys_top mem_subsys_sva u_sva (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_init_wen   (i_init_wen),
    .i_unavailable(o_unavailable),
    .i_debug_mode (i_debug_mode),
    .i_imem_rready(i_imem_rready),
    .i_imem_rvalid(o_imem_rvalid),
    .i_dmem_addr  (i_dmem_addr),
    .i_dmem_rready(i_dmem_rready),
    .i_dmem_rvalid(o_dmem_rvalid),
    .i_psel       (o_apb_psel),
    .i_penable    (o_apb_penable),
    .i_pready     (i_apb_pready)
  );

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Slave power-up word holds each index bit twice
  function automatic logic [31:0] slave_fill(input logic [10:0] idx);
    return {5'h15, idx, 5'h0a, idx};
  endfunction

  // Debug area goes to APB only in debug mode
  function automatic logic to_bridge(input logic [31:0] addr);
    return i_debug_mode && (addr >= DEBUG_AREA_START) && (addr <= DEBUG_AREA_END);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    if (cond !== 1'b1) begin
      $display("ERROR %s", what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // ====================
  // Bus drivers
  // ====================

  task automatic init_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    i_init_addr <= addr;
    i_init_data <= data;
    i_init_wen  <= 1'b1;
  endtask

  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    i_imem_addr   <= addr;
    i_imem_rready <= 1'b1;
    @(posedge clk);
    i_imem_rready <= 1'b0;
    // Valid and data sit in the cycle after the request edge
    @(negedge clk);
    check_true(o_imem_rvalid, "fetch valid missing one cycle after the request");
    data = o_imem_rdata;
  endtask

  task automatic dmem_write(input logic [31:0] addr, input logic [31:0] data);
    logic bridge;
    int   waits;
    waits = 0;
    @(posedge clk);
    bridge = to_bridge(addr);
    i_dmem_addr   <= addr;
    i_dmem_wdata  <= data;
    i_dmem_wvalid <= 1'b1;
    // Request held until ready
    do begin
      @(negedge clk);
      waits++;
      if (!bridge) begin
        check_true(!o_apb_psel, "APB select raised for a write routed to RAM");
      end
    end while (!o_dmem_wready);
    if (bridge) begin
      check_true(o_apb_penable && i_apb_pready, "write ready outside the APB pready cycle");
      check_true(o_apb_pwrite, "APB write strobe low during a debug write");
      check_eq("apb paddr", 32'(addr[APB_AW-1:0]), 32'(o_apb_paddr));
      check_eq("apb pwdata", data, o_apb_pwdata);
    end else begin
      check_true(waits == 1, "write ready low for a write routed to RAM");
    end
    // Completion edge
    @(posedge clk);
    i_dmem_wvalid <= 1'b0;
  endtask

  task automatic dmem_read(input logic [31:0] addr, output logic [31:0] data);
    logic bridge;
    @(posedge clk);
    bridge = to_bridge(addr);
    i_dmem_addr   <= addr;
    i_dmem_rready <= 1'b1;
    @(posedge clk);
    // RAM reads are one-cycle pulses
    if (!bridge) begin
      i_dmem_rready <= 1'b0;
    end
    do begin
      @(negedge clk);
      if (!bridge) begin
        check_true(!o_apb_psel, "APB select raised for a read routed to RAM");
      end
    end while (!o_dmem_rvalid);
    data = o_dmem_rdata;
    if (bridge) begin
      check_true(o_apb_penable && i_apb_pready, "read valid outside the APB pready cycle");
      @(posedge clk);
      i_dmem_rready <= 1'b0;
    end
  endtask

  // ====================
  // APB slave model
  // ====================

  initial begin
    for (int i = 0; i < 2048; i++) begin
      slave_mem[i] = slave_fill(11'(i));
    end
    forever begin
      @(posedge clk);
      if (o_apb_psel && !o_apb_penable) begin
        // SETUP seen so pick zero or one wait state
        wait_rng = xorshift32(wait_rng);
        i_apb_pready <= wait_rng[0];
        i_apb_prdata <= slave_mem[o_apb_paddr[APB_AW-1:2]];
      end else if (o_apb_psel && o_apb_penable && !i_apb_pready) begin
        i_apb_pready <= 1'b1;
      end else begin
        // Write lands on the completion edge
        if (o_apb_psel && o_apb_penable && o_apb_pwrite) begin
          slave_mem[o_apb_paddr[APB_AW-1:2]] = o_apb_pwdata;
        end
        i_apb_pready <= 1'b0;
      end
    end
  end

  // Run bound
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout, run did not end within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ====================
  // Tests
  // ====================

  initial begin
    logic [31:0] addr_list [8];
    logic [31:0] data_list [8];
    logic [31:0] word;
    logic [31:0] got;
    rng = 32'hb50eaeb8;
    errors = 0;
    checks = 0;
    test_errors = 0;
    tests_run = 0;
    i_init_addr   = '0;
    i_init_data   = '0;
    i_init_wen    = 1'b0;
    i_debug_mode  = 1'b0;
    i_imem_addr   = '0;
    i_imem_rready = 1'b0;
    i_dmem_addr   = '0;
    i_dmem_wdata  = '0;
    i_dmem_wvalid = 1'b0;
    i_dmem_rready = 1'b0;
    @(posedge reset_n);
    @(negedge clk);
    check_eq("reset levels", 32'h0,
             32'({o_imem_rvalid, o_dmem_rvalid, o_apb_psel, o_apb_penable, o_unavailable}));
    check_eq("reset tohost", 32'h0, o_tohost);

    // Init load then fetch
    fetch_word(32'h0000_3FFC, got);
    check_eq("untouched fetch", NOP_WORD, got);
    for (int i = 0; i < N_INIT; i++) begin
      word = next_word();
      addr_list[i] = 32'((i * 256 + word[7:0]) * 4);
      data_list[i] = next_word();
      init_write(addr_list[i], data_list[i]);
    end
    // Bit 14 set puts this word outside the window
    init_write(32'h0000_7FF8, next_word());
    @(negedge clk);
    check_true(o_unavailable, "unavailable low while init loading is under way");
    @(posedge clk);
    i_init_wen <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_true(!o_unavailable, "unavailable still high after init loading ended");
    fetch_word(32'h0000_3FF8, got);
    check_eq("window fetch", NOP_WORD, got);
    for (int i = 0; i < N_INIT; i++) begin
      fetch_word(addr_list[i], got);
      check_eq("init fetch", data_list[i], got);
    end
    finish_test("init_fetch");

    // RAM write and read with debug mode toggled outside the area
    for (int i = 0; i < N_DATA; i++) begin
      word = next_word();
      addr_list[i] = 32'h2000_0000 | 32'((i * 512 + word[8:0]) * 4);
      data_list[i] = next_word();
      @(posedge clk);
      i_debug_mode <= i[0];
      dmem_write(addr_list[i], data_list[i]);
    end
    for (int i = 0; i < N_DATA; i++) begin
      dmem_read(addr_list[i], got);
      check_eq("data readback", data_list[i], got);
    end
    finish_test("data_ram");

    // tohost capture and hold
    word = next_word();
    dmem_write(TOHOST_ADDR, word);
    @(negedge clk);
    check_eq("tohost capture", word, o_tohost);
    dmem_write(TOHOST_ADDR + 32'h4, next_word());
    @(negedge clk);
    check_eq("tohost hold", word, o_tohost);
    finish_test("tohost");

    // Debug area writes over APB
    @(posedge clk);
    i_debug_mode <= 1'b1;
    for (int i = 0; i < N_DBG; i++) begin
      word = next_word();
      addr_list[i] = DEBUG_AREA_START | 32'((i * 512 + word[7:0]) * 4);
      data_list[i] = next_word();
      dmem_write(addr_list[i], data_list[i]);
      @(negedge clk);
      check_eq("slave word", data_list[i], slave_mem[addr_list[i][APB_AW-1:2]]);
    end
    finish_test("debug_write");

    // Debug area reads and one never written word
    for (int i = 0; i < N_DBG; i++) begin
      dmem_read(addr_list[i], got);
      check_eq("debug readback", data_list[i], got);
    end
    dmem_read(DEBUG_AREA_START + 32'h1FFC, got);
    check_eq("debug fill read", slave_fill(11'h7FF), got);
    finish_test("debug_read");

    // Same area with debug mode off lands in RAM
    @(posedge clk);
    i_debug_mode <= 1'b0;
    word = next_word();
    dmem_write(DEBUG_AREA_START + 32'h10, word);
    dmem_read(DEBUG_AREA_START + 32'h10, got);
    check_eq("debug off readback", word, got);
    finish_test("debug_off");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, checks, errors, dut0.u_sva.fail_count);
    if (errors == 0 && dut0.u_sva.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
source/mem_subsys_pkg.sv
source/init_loader.sv
source/fetch_unit.sv
source/data_ram.sv
source/data_router.sv
source/dbg_apb_master.sv
source/mem_subsys_top.sv
tb/tb_clock.sv
tb/mem_subsys_sva.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f mem_subsys.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion errors accumulate so the testbench prints its summary
out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
